//--- list.f
cpuPkg.sv
aluCore.sv
decimalAdjust.sv
regFile.sv
statusReg.sv
progCounter.sv
datapathTop.sv
tbDatapath.sv

//--- tbDatapath.sv
// self-checking testbench; model runs one command ahead and assumes one command per cycle
`timescale 1ns/1ns
`default_nettype none

module tbDatapath import cpuPkg::*; ();

    // cycles per test with the two idle cycles that close it
    localparam int resetCycles = 16;
    localparam int resetTestCmds = 6;
    localparam int arithCmds = 602;
    localparam int logicCmds = 202;
    localparam int decimalCmds = 334;
    localparam int regCmds = 70;
    localparam int branchCmds = 58;
    localparam int totalCmds = resetTestCmds + arithCmds + logicCmds + decimalCmds
        + regCmds + branchCmds;
    localparam int cycleLimit = 2 * totalCmds + resetCycles;

    logic phi2;
    logic reset;
    logic cmdValid;
    microOp_t cmdOp;
    regSel_t cmdReg;
    regSel_t cmdDst;
    byte_t cmdOperand;
    byte_t acc;
    byte_t xReg;
    byte_t yReg;
    byte_t stackPtr;
    byte_t status;
    word_t pc;

    // model state after the last accepted command
    byte_t expA;
    byte_t expX;
    byte_t expY;
    byte_t expS;
    byte_t expP;
    word_t expPc;
    // model state after the command now on the inputs
    byte_t nextA;
    byte_t nextX;
    byte_t nextY;
    byte_t nextS;
    byte_t nextP;
    word_t nextPc;

    int seed = 22;
    int errCount = 0;
    int testErrStart = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycleCount = 0;

    datapathTop UUT (
        .phi2(phi2),
        .reset(reset),
        .cmdValid(cmdValid),
        .cmdOp(cmdOp),
        .cmdReg(cmdReg),
        .cmdDst(cmdDst),
        .cmdOperand(cmdOperand),
        .acc(acc),
        .xReg(xReg),
        .yReg(yReg),
        .stackPtr(stackPtr),
        .status(status),
        .pc(pc)
    );

    always #4 phi2 = ~phi2;

    // model advances on the same edge as the DUT
    always @(posedge phi2) begin
        if (reset) begin
            expA <= 8'h00;
            expX <= 8'h00;
            expY <= 8'h00;
            expS <= stackReset;
            expP <= statusReset;
            expPc <= pcReset;
        end else if (cmdValid) begin
            expA <= nextA;
            expX <= nextX;
            expY <= nextY;
            expS <= nextS;
            expP <= nextP;
            expPc <= nextPc;
        end
    end

    // run limit
    always @(posedge phi2) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // state right after reset is released
    resetValues: assert property (@(posedge phi2) $fell(reset) |-> acc == 8'h00
        && xReg == 8'h00 && yReg == 8'h00 && stackPtr == 8'hFF
        && status == statusReset && pc == pcReset)
        else begin
            $display("MISMATCH at %0t: state after reset is wrong", $time);
            errCount++;
        end

    // DUT against model on every cycle out of reset
    accCheck: assert property (@(posedge phi2) disable iff (reset) acc == expA)
        else begin
            $display("MISMATCH at %0t: acc %h, expected %h", $time, $sampled(acc),
                $sampled(expA));
            errCount++;
        end
    xCheck: assert property (@(posedge phi2) disable iff (reset) xReg == expX)
        else begin
            $display("MISMATCH at %0t: xReg %h, expected %h", $time, $sampled(xReg),
                $sampled(expX));
            errCount++;
        end
    yCheck: assert property (@(posedge phi2) disable iff (reset) yReg == expY)
        else begin
            $display("MISMATCH at %0t: yReg %h, expected %h", $time, $sampled(yReg),
                $sampled(expY));
            errCount++;
        end
    stackCheck: assert property (@(posedge phi2) disable iff (reset) stackPtr == expS)
        else begin
            $display("MISMATCH at %0t: stackPtr %h, expected %h", $time,
                $sampled(stackPtr), $sampled(expS));
            errCount++;
        end
    statusCheck: assert property (@(posedge phi2) disable iff (reset) status == expP)
        else begin
            $display("MISMATCH at %0t: status %b, expected %b", $time, $sampled(status),
                $sampled(expP));
            errCount++;
        end
    pcCheck: assert property (@(posedge phi2) disable iff (reset) pc == expPc)
        else begin
            $display("MISMATCH at %0t: pc %h, expected %h", $time, $sampled(pc),
                $sampled(expPc));
            errCount++;
        end

    function automatic byte_t randByte();
        logic [31:0] v;
        v = $random(seed);
        return v[7:0];
    endfunction

    function automatic logic randBit();
        logic [31:0] v;
        v = $random(seed);
        return v[0];
    endfunction

    function automatic int bcdToInt(input byte_t b);
        return int'(b[7:4]) * 10 + int'(b[3:0]);
    endfunction

    function automatic byte_t intToBcd(input int v);
        byte_t r;
        r[7:4] = 4'(v / 10);
        r[3:0] = 4'(v % 10);
        return r;
    endfunction

    // two random decimal digits
    function automatic byte_t randBcd();
        logic [31:0] v;
        v = $random(seed);
        return intToBcd(int'(v % 32'd100));
    endfunction

    function automatic byte_t regValue(input regSel_t sel);
        case (sel)
            regA: return expA;
            regX: return expX;
            regY: return expY;
            default: return expS;
        endcase
    endfunction

    task automatic writeReg(input regSel_t sel, input byte_t val);
        case (sel)
            regA: nextA = val;
            regX: nextX = val;
            regY: nextY = val;
            default: nextS = val;
        endcase
    endtask

    task automatic setNz(input byte_t r);
        nextP[flagN] = r[7];
        nextP[flagZ] = (r == 8'h00);
    endtask

    // expected state after one command
    task automatic predict(input microOp_t op, input regSel_t src, input regSel_t dst,
                           input byte_t m);
        byte_t r;
        int ci;
        int uSum;
        int sSum;
        int dec;
        logic carry;
        begin
            nextA = expA;
            nextX = expX;
            nextY = expY;
            nextS = expS;
            nextP = expP;
            nextPc = expPc + 16'd1;
            ci = int'(expP[flagC]);
            case (op)
                opAdc, opSbc: begin
                    // signed result out of range means V
                    if (op == opAdc) begin
                        uSum = int'(expA) + int'(m) + ci;
                        sSum = int'($signed(expA)) + int'($signed(m)) + ci;
                        carry = (uSum > 255);
                    end else begin
                        uSum = int'(expA) - int'(m) - (1 - ci);
                        sSum = int'($signed(expA)) - int'($signed(m)) - (1 - ci);
                        carry = (uSum >= 0);
                    end
                    r = uSum[7:0];
                    // decimal mode works on the digit values
                    if (expP[flagD]) begin
                        if (op == opAdc) begin
                            dec = bcdToInt(expA) + bcdToInt(m) + ci;
                            carry = (dec > 99);
                            if (carry) dec = dec - 100;
                        end else begin
                            dec = bcdToInt(expA) - bcdToInt(m) - (1 - ci);
                            carry = (dec >= 0);
                            if (!carry) dec = dec + 100;
                        end
                        r = intToBcd(dec);
                    end
                    nextA = r;
                    setNz(r);
                    nextP[flagC] = carry;
                    nextP[flagV] = (sSum > 127) || (sSum < -128);
                end
                opAnd, opOra, opEor: begin
                    if (op == opAnd) r = expA & m;
                    else if (op == opOra) r = expA | m;
                    else r = expA ^ m;
                    nextA = r;
                    setNz(r);
                end
                opLsr: begin
                    nextA = expA >> 1;
                    nextP[flagC] = expA[0];
                    setNz(expA >> 1);
                end
                opLoad: begin
                    writeReg(dst, m);
                    setNz(m);
                end
                opTransfer: begin
                    writeReg(dst, regValue(src));
                    // move into S keeps the flags
                    if (dst != regS) setNz(regValue(src));
                end
                opCmp: begin
                    nextP[flagC] = (regValue(src) >= m);
                    setNz(regValue(src) - m);
                end
                opBit: begin
                    nextP[flagN] = m[7];
                    nextP[flagV] = m[6];
                    nextP[flagZ] = ((expA & m) == 8'h00);
                end
                opSec: nextP[flagC] = 1'b1;
                opClc: nextP[flagC] = 1'b0;
                opSed: nextP[flagD] = 1'b1;
                opCld: nextP[flagD] = 1'b0;
                opSei: nextP[flagI] = 1'b1;
                opCli: nextP[flagI] = 1'b0;
                opClv: nextP[flagV] = 1'b0;
                opBcc, opBcs: begin
                    // taken branch adds the signed offset to the stepped pc
                    if ((op == opBcc) == !expP[flagC]) begin
                        nextPc = expPc + 16'd1 + {{8{m[7]}}, m};
                    end
                end
                default: nextPc = expPc + 16'd1;
            endcase
        end
    endtask

    task automatic runCommand(input microOp_t op, input regSel_t src, input regSel_t dst,
                              input byte_t operand);
        @(negedge phi2);
        cmdValid = 1'b1;
        cmdOp = op;
        cmdReg = src;
        cmdDst = dst;
        cmdOperand = operand;
        predict(op, src, dst, operand);
    endtask

    // cmdValid low with junk on the other inputs
    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge phi2);
            cmdValid = 1'b0;
            cmdOp = opAdc;
            cmdOperand = randByte();
        end
    endtask

    task automatic setCarry(input logic c);
        if (c) runCommand(opSec, regA, regA, 8'h00);
        else runCommand(opClc, regA, regA, 8'h00);
    endtask

    task automatic finishTest(input string name);
        int newErrors;
        idleCycles(2);
        newErrors = errCount - testErrStart;
        testErrStart = errCount;
        testsRun++;
        if (newErrors != 0) testsFailed++;
        $display("test %s finished with %0d errors", name, newErrors);
    endtask

    initial begin
        int i;
        byte_t v;
        regSel_t sel;
        phi2 = 1'b0;
        reset = 1'b1;
        cmdValid = 1'b0;
        cmdOp = opNop;
        cmdReg = regA;
        cmdDst = regA;
        cmdOperand = 8'h00;
        repeat (resetCycles) @(posedge phi2);
        @(negedge phi2);
        reset = 1'b0;

        // reset state that idle cycles must hold
        idleCycles(4);
        finishTest("reset and idle");

        // binary add and subtract
        for (i = 0; i < 200; i++) begin
            runCommand(opLoad, regA, regA, randByte());
            setCarry(randBit());
            if (i % 2 == 0) runCommand(opAdc, regA, regA, randByte());
            else runCommand(opSbc, regA, regA, randByte());
        end
        finishTest("binary adc and sbc");

        // logic, shift and bit test
        for (i = 0; i < 100; i++) begin
            runCommand(opLoad, regA, regA, randByte());
            case (i % 5)
                0: runCommand(opAnd, regA, regA, randByte());
                1: runCommand(opOra, regA, regA, randByte());
                2: runCommand(opEor, regA, regA, randByte());
                3: runCommand(opLsr, regA, regA, randByte());
                default: runCommand(opBit, regA, regA, randByte());
            endcase
        end
        finishTest("logic and shift");

        // decimal mode and back to binary
        runCommand(opSed, regA, regA, 8'h00);
        for (i = 0; i < 100; i++) begin
            runCommand(opLoad, regA, regA, randBcd());
            setCarry(randBit());
            if (i % 2 == 0) runCommand(opAdc, regA, regA, randBcd());
            else runCommand(opSbc, regA, regA, randBcd());
        end
        runCommand(opCld, regA, regA, 8'h00);
        for (i = 0; i < 10; i++) begin
            runCommand(opLoad, regA, regA, randBcd());
            setCarry(randBit());
            runCommand(opAdc, regA, regA, randBcd());
        end
        finishTest("decimal adc and sbc");

        // loads, every transfer pair, compares and flag commands
        runCommand(opLoad, regA, regA, randByte());
        runCommand(opLoad, regA, regX, 8'h00);
        runCommand(opLoad, regA, regY, 8'h80);
        runCommand(opLoad, regA, regS, randByte());
        for (i = 0; i < 16; i++) begin
            runCommand(opTransfer, regSel_t'(i % 4), regSel_t'(i / 4), 8'h00);
        end
        for (i = 0; i < 20; i++) begin
            v = randByte();
            sel = regSel_t'(v[1:0]);
            runCommand(opLoad, regA, sel, v);
            // every fourth compare hits the equal case
            if (i % 4 == 0) runCommand(opCmp, sel, regA, v);
            else runCommand(opCmp, sel, regA, randByte());
        end
        runCommand(opBit, regA, regA, 8'hC0);
        runCommand(opSec, regA, regA, 8'h00);
        runCommand(opClc, regA, regA, 8'h00);
        runCommand(opSed, regA, regA, 8'h00);
        runCommand(opCld, regA, regA, 8'h00);
        runCommand(opSei, regA, regA, 8'h00);
        runCommand(opCli, regA, regA, 8'h00);
        runCommand(opClv, regA, regA, 8'h00);
        finishTest("registers compare and flags");

        // pc stepping and branches over page edges
        repeat (4) runCommand(opNop, regA, regA, randByte());
        setCarry(1'b0);
        repeat (4) runCommand(opBcc, regA, regA, 8'h7F);
        runCommand(opBcs, regA, regA, 8'h10);
        setCarry(1'b1);
        repeat (4) runCommand(opBcs, regA, regA, 8'h80);
        runCommand(opBcc, regA, regA, 8'h05);
        for (i = 0; i < 20; i++) begin
            setCarry(randBit());
            if (randBit()) runCommand(opBcs, regA, regA, randByte());
            else runCommand(opBcc, regA, regA, randByte());
        end
        finishTest("program counter and branches");

        $display("tests run %0d, tests failed %0d, mismatches %0d", testsRun, testsFailed,
            errCount);
        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- datapathTop.sv
// one command per valid cycle, no stall; opLoad writes cmdDst, opTransfer copies cmdReg into cmdDst
`timescale 1ns/1ns
`default_nettype none

module datapathTop import cpuPkg::*; (
    input  logic     phi2,
    input  logic     reset,
    input  logic     cmdValid,
    input  microOp_t cmdOp,
    input  regSel_t  cmdReg,
    input  regSel_t  cmdDst,
    input  byte_t    cmdOperand,
    output byte_t    acc,
    output byte_t    xReg,
    output byte_t    yReg,
    output byte_t    stackPtr,
    output byte_t    status,
    output word_t    pc
);

    byte_t aluA;
    byte_t aluB;
    logic aluCin;
    aluFunc_t aluFunc;
    byte_t aluResult;
    logic aluCarry;
    logic aluOverflow;
    logic aluHalf;
    byte_t adjResult;
    logic decCarry;
    logic bcdEnable;
    byte_t readData;
    byte_t resultVal;
    logic writeEn;
    regSel_t writeSel;

    // operand and function select per command
    always_comb begin
        aluA = acc;
        aluB = cmdOperand;
        aluCin = 1'b0;
        aluFunc = aluSum;
        writeEn = 1'b0;
        writeSel = regA;
        case (cmdOp)
            opAdc: begin
                aluCin = status[flagC];
                writeEn = 1'b1;
            end
            // subtract is add of the inverted operand
            opSbc: begin
                aluB = ~cmdOperand;
                aluCin = status[flagC];
                writeEn = 1'b1;
            end
            opAnd: begin
                aluFunc = aluAnd;
                writeEn = 1'b1;
            end
            opOra: begin
                aluFunc = aluOr;
                writeEn = 1'b1;
            end
            opEor: begin
                aluFunc = aluEor;
                writeEn = 1'b1;
            end
            opLsr: begin
                aluFunc = aluShr;
                writeEn = 1'b1;
            end
            // zero OR operand passes the operand
            opLoad: begin
                aluA = '0;
                aluFunc = aluOr;
                writeEn = 1'b1;
                writeSel = cmdDst;
            end
            opTransfer: begin
                writeEn = 1'b1;
                writeSel = cmdDst;
            end
            // register minus operand, no write back
            opCmp: begin
                aluA = readData;
                aluB = ~cmdOperand;
                aluCin = 1'b1;
            end
            opBit: aluFunc = aluAnd;
            default: aluFunc = aluSum;
        endcase
    end

    // BCD only for ADC and SBC in decimal mode
    assign bcdEnable = status[flagD] && ((cmdOp == opAdc) || (cmdOp == opSbc));
    assign resultVal = (cmdOp == opTransfer) ? readData : adjResult;

    aluCore alu (
        .aluA(aluA),
        .aluB(aluB),
        .carryIn(aluCin),
        .func(aluFunc),
        .result(aluResult),
        .carryOut(aluCarry),
        .overflow(aluOverflow),
        .halfCarry(aluHalf)
    );

    decimalAdjust bcd (
        .binResult(aluResult),
        .binCarry(aluCarry),
        .halfCarry(aluHalf),
        .isSubtract(cmdOp == opSbc),
        .enable(bcdEnable),
        .adjResult(adjResult),
        .decCarry(decCarry)
    );

    regFile regs (
        .phi2(phi2),
        .reset(reset),
        .writeEn(cmdValid && writeEn),
        .writeSel(writeSel),
        .writeData(resultVal),
        .readSel(cmdReg),
        .readData(readData),
        .acc(acc),
        .xReg(xReg),
        .yReg(yReg),
        .stackPtr(stackPtr)
    );

    // carry is binary unless decimal adjust ran
    statusReg flags (
        .phi2(phi2),
        .reset(reset),
        .cmdValid(cmdValid),
        .cmdOp(cmdOp),
        .cmdDst(cmdDst),
        .result(resultVal),
        .operand(cmdOperand),
        .acc(acc),
        .carry(decCarry),
        .overflow(aluOverflow),
        .status(status)
    );

    progCounter pcUnit (
        .phi2(phi2),
        .reset(reset),
        .cmdValid(cmdValid),
        .cmdOp(cmdOp),
        .carryFlag(status[flagC]),
        .offset(cmdOperand),
        .pc(pc)
    );

endmodule

`default_nettype wire

//--- progCounter.sv
// pc steps once per accepted command; branch offset is a signed byte added to the stepped pc
`timescale 1ns/1ns
`default_nettype none

module progCounter import cpuPkg::*; (
    input  logic     phi2,
    input  logic     reset,
    input  logic     cmdValid,
    input  microOp_t cmdOp,
    input  logic     carryFlag,
    input  byte_t    offset,
    output word_t    pc
);

    word_t pcInc;
    logic [8:0] lowSum;
    byte_t highNext;
    logic taken;

    // BCC on C clear, BCS on C set
    assign taken = ((cmdOp == opBcc) && !carryFlag) || ((cmdOp == opBcs) && carryFlag);

    assign pcInc = pc + 16'd1;
    assign lowSum = {1'b0, pcInc[7:0]} + {1'b0, offset};

    // page crossing fixes the high byte
    always_comb begin
        highNext = pcInc[15:8];
        if (!offset[7] && lowSum[8]) begin
            highNext = pcInc[15:8] + 8'd1;
        end else if (offset[7] && !lowSum[8]) begin
            highNext = pcInc[15:8] - 8'd1;
        end
    end

    always_ff @(posedge phi2) begin
        if (reset) begin
            pc <= pcReset;
        end else if (cmdValid) begin
            if (taken) begin
                pc <= {highNext, lowSum[7:0]};
            end else begin
                pc <= pcInc;
            end
        end
    end

endmodule

`default_nettype wire

//--- statusReg.sv
// NV-DIZC flags with per-command update; no B flag, bit 4 reads 0 and bit 5 reads 1
`timescale 1ns/1ns
`default_nettype none

module statusReg import cpuPkg::*; (
    input  logic     phi2,
    input  logic     reset,
    input  logic     cmdValid,
    input  microOp_t cmdOp,
    input  regSel_t  cmdDst,
    input  byte_t    result,
    input  byte_t    operand,
    input  byte_t    acc,
    input  logic     carry,
    input  logic     overflow,
    output byte_t    status
);

    logic negFlag;
    logic ovfFlag;
    logic decFlag;
    logic irqFlag;
    logic zeroFlag;
    logic carryFlag;
    logic resultZero;

    assign resultZero = (result == 8'h00);

    always_ff @(posedge phi2) begin
        if (reset) begin
            negFlag <= statusReset[flagN];
            ovfFlag <= statusReset[flagV];
            decFlag <= statusReset[flagD];
            irqFlag <= statusReset[flagI];
            zeroFlag <= statusReset[flagZ];
            carryFlag <= statusReset[flagC];
        end else if (cmdValid) begin
            case (cmdOp)
                // result, carry and overflow already picked by the top
                opAdc, opSbc: begin
                    negFlag <= result[7];
                    zeroFlag <= resultZero;
                    carryFlag <= carry;
                    ovfFlag <= overflow;
                end
                opAnd, opOra, opEor, opLoad: begin
                    negFlag <= result[7];
                    zeroFlag <= resultZero;
                end
                opTransfer: begin
                    // TXS style move leaves flags alone
                    if (cmdDst != regS) begin
                        negFlag <= result[7];
                        zeroFlag <= resultZero;
                    end
                end
                opLsr: begin
                    negFlag <= 1'b0;
                    zeroFlag <= resultZero;
                    carryFlag <= carry;
                end
                // carry set means register >= operand
                opCmp: begin
                    negFlag <= result[7];
                    zeroFlag <= resultZero;
                    carryFlag <= carry;
                end
                // N and V straight from the operand
                opBit: begin
                    negFlag <= operand[7];
                    ovfFlag <= operand[6];
                    zeroFlag <= ((acc & operand) == 8'h00);
                end
                opSec: carryFlag <= 1'b1;
                opClc: carryFlag <= 1'b0;
                opSed: decFlag <= 1'b1;
                opCld: decFlag <= 1'b0;
                opSei: irqFlag <= 1'b1;
                opCli: irqFlag <= 1'b0;
                opClv: ovfFlag <= 1'b0;
                default: carryFlag <= carryFlag;
            endcase
        end
    end

    // pack flags into the 6502 layout
    always_comb begin
        status = '0;
        status[flagN] = negFlag;
        status[flagV] = ovfFlag;
        status[flagOne] = 1'b1;
        status[flagD] = decFlag;
        status[flagI] = irqFlag;
        status[flagZ] = zeroFlag;
        status[flagC] = carryFlag;
    end

    // fixed bits hold across every command
    fixedBits: assert property (@(posedge phi2) cmdValid |=> status[flagOne] && !status[4])
        else $error("statusReg: fixed status bits disturbed");

endmodule

`default_nettype wire

//--- regFile.sv
// A, X, Y and S with one write and one read port; a read in the write cycle sees the old value
`timescale 1ns/1ns
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic    phi2,
    input  logic    reset,
    input  logic    writeEn,
    input  regSel_t writeSel,
    input  byte_t   writeData,
    input  regSel_t readSel,
    output byte_t   readData,
    output byte_t   acc,
    output byte_t   xReg,
    output byte_t   yReg,
    output byte_t   stackPtr
);

    // one register written per enabled edge
    always_ff @(posedge phi2) begin
        if (reset) begin
            acc <= '0;
            xReg <= '0;
            yReg <= '0;
            stackPtr <= stackReset;
        end else if (writeEn) begin
            case (writeSel)
                regA: acc <= writeData;
                regX: xReg <= writeData;
                regY: yReg <= writeData;
                regS: stackPtr <= writeData;
                default: acc <= acc;
            endcase
        end
    end

    // source for transfer and compare
    always_comb begin
        case (readSel)
            regA: readData = acc;
            regX: readData = xReg;
            regY: readData = yReg;
            regS: readData = stackPtr;
            default: readData = acc;
        endcase
    end

    // stack pointer comes up all ones
    stackAfterReset: assert property (@(posedge phi2) reset |=> stackPtr == stackReset)
        else $error("regFile: stack pointer not at reset value after reset");

endmodule

`default_nettype wire

//--- decimalAdjust.sv
// bcd fixup after a binary add or subtract; results are only meaningful for valid bcd operands
`timescale 1ns/1ns
`default_nettype none

module decimalAdjust import cpuPkg::*; (
    input  byte_t binResult,
    input  logic  binCarry,
    input  logic  halfCarry,
    input  logic  isSubtract,
    input  logic  enable,
    output byte_t adjResult,
    output logic  decCarry
);

    always_comb begin
        adjResult = binResult;
        decCarry = binCarry;
        if (enable) begin
            if (!isSubtract) begin
                // low digit over 9 or carried into high digit
                if ((binResult[3:0] > bcdLowLimit) || halfCarry) begin
                    adjResult = adjResult + bcdLowFix;
                end
                // high digit correction, judged on the binary sum
                if (binCarry || (binResult > bcdByteLimit)) begin
                    adjResult = adjResult + bcdHighFix;
                    decCarry = 1'b1;
                end else begin
                    decCarry = 1'b0;
                end
            end else begin
                // borrow out of low digit
                if (!halfCarry) begin
                    adjResult = adjResult - bcdLowFix;
                end
                // borrow out of the byte
                if (!binCarry) begin
                    adjResult = adjResult - bcdHighFix;
                end
                // decimal carry is the binary carry here
                decCarry = binCarry;
            end
        end
    end

endmodule

`default_nettype wire

//--- aluCore.sv
// combinational 8-bit ALU; subtract is done by the caller inverting aluB, shift works on aluA only
`timescale 1ns/1ns
`default_nettype none

module aluCore import cpuPkg::*; (
    input  byte_t    aluA,
    input  byte_t    aluB,
    input  logic     carryIn,
    input  aluFunc_t func,
    output byte_t    result,
    output logic     carryOut,
    output logic     overflow,
    output logic     halfCarry
);

    // full sum with carry out in bit 8
    logic [8:0] sum;
    // low nibble sum, bit 4 is the half carry
    logic [4:0] nibbleSum;

    assign sum = {1'b0, aluA} + {1'b0, aluB} + {8'b0, carryIn};
    assign nibbleSum = {1'b0, aluA[3:0]} + {1'b0, aluB[3:0]} + {4'b0, carryIn};
    assign halfCarry = nibbleSum[4];

    always_comb begin
        result = '0;
        carryOut = 1'b0;
        overflow = 1'b0;
        case (func)
            aluSum: begin
                result = sum[7:0];
                carryOut = sum[8];
                // same-sign inputs giving a result of other sign
                overflow = (aluA[7] == aluB[7]) && (sum[7] != aluA[7]);
            end
            aluAnd: result = aluA & aluB;
            aluOr: result = aluA | aluB;
            aluEor: result = aluA ^ aluB;
            aluShr: begin
                // zero fill from the top, bit 0 falls into carry
                result = {1'b0, aluA[7:1]};
                carryOut = aluA[0];
            end
            default: result = '0;
        endcase
    end

    // decoder must always give a known function
    always_comb begin
        funcKnown: assert final (!$isunknown(func))
            else $error("aluCore: func is unknown");
    end

endmodule

`default_nettype wire

//--- cpuPkg.sv
// shared types and constants for the datapath; the command set is local to this design, not 6502 opcodes
`default_nettype none

package cpuPkg;

    // data and address widths
    typedef logic [7:0] byte_t;
    typedef logic [15:0] word_t;

    // one command per accepted cycle
    typedef enum logic [4:0] {
        opNop,
        opAdc, opSbc,
        opAnd, opOra, opEor, opLsr,
        opLoad, opTransfer, opCmp, opBit,
        opSec, opClc, opSed, opCld, opSei, opCli, opClv,
        opBcc, opBcs
    } microOp_t;

    typedef enum logic [2:0] {
        aluSum,
        aluAnd,
        aluOr,
        aluEor,
        aluShr
    } aluFunc_t;

    typedef enum logic [1:0] {
        regA,
        regX,
        regY,
        regS
    } regSel_t;

    // status bit positions, NV-BDIZC
    localparam int flagN = 7;
    localparam int flagV = 6;
    localparam int flagOne = 5;
    localparam int flagD = 3;
    localparam int flagI = 2;
    localparam int flagZ = 1;
    localparam int flagC = 0;

    // values after reset
    localparam byte_t statusReset = 8'h24;
    localparam byte_t stackReset = 8'hFF;
    localparam word_t pcReset = 16'h0200;

    // bcd correction constants
    localparam logic [3:0] bcdLowLimit = 4'd9;
    localparam byte_t bcdByteLimit = 8'h99;
    localparam byte_t bcdLowFix = 8'h06;
    localparam byte_t bcdHighFix = 8'h60;

endpackage

`default_nettype wire
